// File: hdl/conv_consts.svh
// Convolution kernel sizes and the LFSR constants that feed its operands.
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// kernel geometry
// ~~~~~~~~~~~~~~~~~~~~
`define CONV_TAPS   3    // filter taps per output.
`define CONV_OUTS   8    // outputs in one row.
`define CONV_PIXELS 10   // window length, taps plus outputs minus one.

// ~~~~~~~~~~~~~~~~~~~~
// operand source
// ~~~~~~~~~~~~~~~~~~~~
`define LFSR_MASK     16'hB400   // galois feedback taps.
`define LFSR_ZERO_SUB 16'h0001   // replaces an all-zero seed, which would lock up.

`endif

// File: hdl/conv_pkg.sv
// Types shared by the convolution kernel control and datapath blocks.
package conv_pkg;

  // block-level control states.
  typedef enum logic [2:0] {
    IDLE,
    LOAD_COEF,
    LOAD_PIXEL,
    RUN,
    DONE
  } conv_state_e;

  typedef logic signed [7:0]  pixel_t;    // operand or result byte.
  typedef logic signed [17:0] acc_t;      // holds three full products without overflow.
  typedef logic        [15:0] seed_t;     // lfsr seed and state.
  typedef logic        [1:0]  tap_idx_t;
  typedef logic        [2:0]  out_idx_t;

endpackage

// File: hdl/conv_ctl_if.sv
// Steering strobes and loop indices shared by the kernel control and data blocks.
interface conv_ctl_if;

  // strobes from the control FSM.
  logic seed_load;
  logic coef_load;
  logic pixel_load;
  logic mac_en;
  logic row_write;

  // indices and flags from the loop counters.
  conv_pkg::tap_idx_t tap_idx;
  conv_pkg::out_idx_t out_idx;
  logic               tap_last;
  logic               out_last;
  logic               load_last;

  modport fsm (
    output seed_load, coef_load, pixel_load, mac_en, row_write,
    input  tap_idx, out_idx, tap_last, out_last, load_last
  );

  modport counter (
    input  seed_load, coef_load, pixel_load, mac_en, row_write,
    output tap_idx, out_idx, tap_last, out_last, load_last
  );

  modport source (
    input seed_load, coef_load, pixel_load
  );

  modport datapath (
    input coef_load, pixel_load, mac_en, row_write, tap_idx, out_idx
  );

endinterface

// File: hdl/conv_ctrl_fsm.sv
// Block-level FSM with ap_ctrl_chain handshake that sequences the load and compute phases.
module conv_ctrl_fsm (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       ap_start,
  input  logic       ap_continue,
  output logic       ap_done,
  output logic       ap_idle,
  output logic       ap_ready,
  conv_ctl_if.fsm    ctl
);

  conv_pkg::conv_state_e state_q;
  conv_pkg::conv_state_e state_d;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= conv_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      conv_pkg::IDLE: begin
        if (ap_start) state_d = conv_pkg::LOAD_COEF;
      end
      conv_pkg::LOAD_COEF: begin
        if (ctl.load_last) state_d = conv_pkg::LOAD_PIXEL;
      end
      conv_pkg::LOAD_PIXEL: begin
        if (ctl.load_last) state_d = conv_pkg::RUN;
      end
      conv_pkg::RUN: begin
        if (ctl.out_last && ctl.tap_last) state_d = conv_pkg::DONE;
      end
      conv_pkg::DONE: begin
        if (ap_continue) state_d = conv_pkg::IDLE; // row stays put until released.
      end
      default: state_d = conv_pkg::IDLE;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // strobes and status
  // ~~~~~~~~~~~~~~~~~~~~
  assign ctl.seed_load  = (state_q == conv_pkg::IDLE) && ap_start; // the start edge seeds.
  assign ctl.coef_load  = (state_q == conv_pkg::LOAD_COEF);
  assign ctl.pixel_load = (state_q == conv_pkg::LOAD_PIXEL);
  assign ctl.mac_en     = (state_q == conv_pkg::RUN);
  assign ctl.row_write  = (state_q == conv_pkg::RUN) && ctl.tap_last;

  assign ap_idle  = (state_q == conv_pkg::IDLE);
  assign ap_done  = (state_q == conv_pkg::DONE);
  assign ap_ready = (state_q == conv_pkg::LOAD_PIXEL) && ctl.load_last; // inputs consumed.

endmodule

// File: hdl/conv_loop_counter.sv
// Load, tap and output loop counters with their last-iteration flags.
`include "conv_consts.svh"

module conv_loop_counter (
  input  logic        clk,
  input  logic        arst_n,
  conv_ctl_if.counter ctl
);

  logic [3:0] load_cnt;
  logic [3:0] load_limit;
  logic       load_phase;

  assign load_phase = ctl.coef_load || ctl.pixel_load;
  assign load_limit = ctl.coef_load ? 4'(`CONV_TAPS - 1) : 4'(`CONV_PIXELS - 1);

  assign ctl.load_last = load_phase && (load_cnt == load_limit);
  assign ctl.tap_last  = (ctl.tap_idx == conv_pkg::tap_idx_t'(`CONV_TAPS - 1));
  assign ctl.out_last  = (ctl.out_idx == conv_pkg::out_idx_t'(`CONV_OUTS - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      load_cnt    <= '0;
      ctl.tap_idx <= '0;
      ctl.out_idx <= '0;
    end else begin
      if (load_phase && !ctl.load_last) begin
        load_cnt <= load_cnt + 4'd1;
      end else begin
        load_cnt <= '0; // ready for the next phase.
      end

      if (ctl.mac_en) begin
        if (ctl.tap_last) begin
          ctl.tap_idx <= '0;
          ctl.out_idx <= ctl.out_last ? '0 : ctl.out_idx + 3'd1;
        end else begin
          ctl.tap_idx <= ctl.tap_idx + 2'd1;
        end
      end else begin
        ctl.tap_idx <= '0;
        ctl.out_idx <= '0;
      end
    end
  end

endmodule

// File: hdl/lfsr_source.sv
// Seeded 16-bit Galois LFSR that hands out one operand byte per step.
`include "conv_consts.svh"

module lfsr_source (
  input  logic              clk,
  input  logic              arst_n,
  input  conv_pkg::seed_t   seed,
  conv_ctl_if.source        ctl,
  output conv_pkg::pixel_t  operand
);

  conv_pkg::seed_t state_q;
  conv_pkg::seed_t state_nxt;

  always_comb begin
    state_nxt = state_q >> 1;
    if (state_q[0]) state_nxt = state_nxt ^ `LFSR_MASK;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= `LFSR_ZERO_SUB;
    end else if (ctl.seed_load) begin
      state_q <= (seed == '0) ? `LFSR_ZERO_SUB : seed;
    end else if (ctl.coef_load || ctl.pixel_load) begin
      state_q <= state_nxt;
    end
  end

  assign operand = conv_pkg::pixel_t'(state_nxt[7:0]); // byte of the state being stepped into.

endmodule

// File: hdl/conv_datapath.sv
// Coefficient and pixel registers, multiply-accumulate, output row and readback mux.
`include "conv_consts.svh"

module conv_datapath (
  input  logic              clk,
  input  logic              arst_n,
  input  conv_pkg::pixel_t  operand,
  input  conv_pkg::out_idx_t out_sel,
  conv_ctl_if.datapath      ctl,
  output conv_pkg::pixel_t  out_data
);

  conv_pkg::pixel_t coef [`CONV_TAPS];
  conv_pkg::pixel_t pix  [`CONV_PIXELS];
  conv_pkg::pixel_t row  [`CONV_OUTS];
  conv_pkg::acc_t   acc;
  conv_pkg::acc_t   acc_sum;
  logic signed [15:0] product;
  logic [3:0]       win_idx;

  // ~~~~~~~~~~~~~~~~~~~~
  // operand capture
  // ~~~~~~~~~~~~~~~~~~~~
  // bytes enter at the top, so the first one taken ends up at index 0.
  always_ff @(posedge clk) begin
    if (ctl.coef_load) begin
      for (int k = 0; k < `CONV_TAPS - 1; k++) begin
        coef[k] <= coef[k + 1];
      end
      coef[`CONV_TAPS - 1] <= operand;
    end
    if (ctl.pixel_load) begin
      for (int p = 0; p < `CONV_PIXELS - 1; p++) begin
        pix[p] <= pix[p + 1];
      end
      pix[`CONV_PIXELS - 1] <= operand;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // multiply-accumulate
  // ~~~~~~~~~~~~~~~~~~~~
  assign win_idx = {1'b0, ctl.out_idx} + {2'b00, ctl.tap_idx};
  assign product = pix[win_idx] * coef[ctl.tap_idx];
  assign acc_sum = ((ctl.tap_idx == '0) ? '0 : acc) + conv_pkg::acc_t'(product);

  always_ff @(posedge clk) begin
    if (ctl.mac_en) acc <= acc_sum;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int o = 0; o < `CONV_OUTS; o++) begin
        row[o] <= '0;
      end
    end else if (ctl.row_write) begin
      row[ctl.out_idx] <= conv_pkg::pixel_t'(acc_sum[7:0]); // wraps, no saturation.
    end
  end

  assign out_data = row[out_sel];

endmodule

// File: hdl/conv_layer_random.sv
// Convolution kernel top level with ap_ctrl_chain control and LFSR-fed operands.
module conv_layer_random (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               ap_start,
  input  logic               ap_continue,
  input  conv_pkg::seed_t    seed,
  input  conv_pkg::out_idx_t out_sel,
  output logic               ap_done,
  output logic               ap_idle,
  output logic               ap_ready,
  output conv_pkg::pixel_t   out_data
);

  conv_pkg::pixel_t operand;

  conv_ctl_if ctl ();

  conv_ctrl_fsm u_ctrl_fsm (
    .clk         (clk),
    .arst_n      (arst_n),
    .ap_start    (ap_start),
    .ap_continue (ap_continue),
    .ap_done     (ap_done),
    .ap_idle     (ap_idle),
    .ap_ready    (ap_ready),
    .ctl         (ctl.fsm)
  );

  conv_loop_counter u_loop_counter (
    .clk    (clk),
    .arst_n (arst_n),
    .ctl    (ctl.counter)
  );

  lfsr_source u_lfsr_source (
    .clk     (clk),
    .arst_n  (arst_n),
    .seed    (seed),
    .ctl     (ctl.source),
    .operand (operand)
  );

  conv_datapath u_datapath (
    .clk      (clk),
    .arst_n   (arst_n),
    .operand  (operand),
    .out_sel  (out_sel),
    .ctl      (ctl.datapath),
    .out_data (out_data)
  );

endmodule

// File: sim/conv_layer_random_assert.sv
// Protocol checks on the ap_ctrl_chain status outputs of the convolution kernel.
module conv_layer_random_assert (
  input logic clk,
  input logic arst_n,
  input logic ap_continue,
  input logic ap_done,
  input logic ap_idle,
  input logic ap_ready
);

  // done is a level that only the consumer may clear.
  done_holds: assert property (@(posedge clk) disable iff (!arst_n)
    ap_done && !ap_continue |=> ap_done)
    else $error("ap_done dropped before ap_continue was seen");

  ready_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    ap_ready |=> !ap_ready)
    else $error("ap_ready stayed high for more than one cycle");

  idle_not_done: assert property (@(posedge clk) disable iff (!arst_n)
    !(ap_idle && ap_done))
    else $error("ap_idle and ap_done were high together");

endmodule

bind conv_layer_random conv_layer_random_assert u_assert (
  .clk         (clk),
  .arst_n      (arst_n),
  .ap_continue (ap_continue),
  .ap_done     (ap_done),
  .ap_idle     (ap_idle),
  .ap_ready    (ap_ready)
);

// File: sim/tb_conv_layer_random.sv
// Self-checking testbench for the convolution kernel, driven from a pattern file.
`include "conv_consts.svh"

module tb_conv_layer_random;

  localparam int RESET_CYCLES   = 10;
  localparam int DONE_EDGES     = 38;  // the start edge counts as the first.
  localparam int MAX_IDLE_GAP   = 8;
  localparam int MAX_HOLD_EXTRA = 8;
  localparam int MAX_PATTERNS   = 16;

  typedef struct packed {
    logic done;
    logic idle;
    logic ready;
  } status_t;

  localparam status_t ST_IDLE = 3'b010;
  localparam status_t ST_BUSY = 3'b000;
  localparam status_t ST_DONE = 3'b100;

  logic               clk;
  logic               arst_n;
  logic               ap_start;
  logic               ap_continue;
  conv_pkg::seed_t    seed;
  conv_pkg::out_idx_t out_sel;
  logic               ap_done;
  logic               ap_idle;
  logic               ap_ready;
  conv_pkg::pixel_t   out_data;

  conv_pkg::seed_t  seeds    [MAX_PATTERNS];
  conv_pkg::pixel_t exp_rows [MAX_PATTERNS][`CONV_OUTS];
  int               n_patterns = 0;

  conv_layer_random dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .ap_start    (ap_start),
    .ap_continue (ap_continue),
    .seed        (seed),
    .out_sel     (out_sel),
    .ap_done     (ap_done),
    .ap_idle     (ap_idle),
    .ap_ready    (ap_ready),
    .out_data    (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic stop_with_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_byte(input conv_pkg::pixel_t got, input conv_pkg::pixel_t exp,
                            input string what);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %02h, expected %02h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_ctrl(input status_t got, input status_t exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: done/idle/ready got %03b, expected %03b",
               $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  function automatic status_t read_status();
    return {ap_done, ap_idle, ap_ready};
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic load_patterns();
    int               fd;
    int               code;
    int               fields;
    string            line;
    conv_pkg::seed_t  s;
    conv_pkg::pixel_t b0, b1, b2, b3, b4, b5, b6, b7;
    fd = $fopen("sim/conv_patterns.txt", "r");
    if (fd == 0) begin
      $display("ERROR: the pattern file sim/conv_patterns.txt could not be opened");
      stop_with_failure();
    end else begin
      while (!$feof(fd) && n_patterns < MAX_PATTERNS) begin
        line = "";
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
          fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                           s, b0, b1, b2, b3, b4, b5, b6, b7);
          if (fields == 9) begin
            seeds[n_patterns]    = s;
            exp_rows[n_patterns] = '{b0, b1, b2, b3, b4, b5, b6, b7};
            n_patterns++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_reset_state();
    for (int i = 0; i < `CONV_OUTS; i++) begin
      @(posedge clk);
      out_sel <= conv_pkg::out_idx_t'(i);
      @(negedge clk);
      check_ctrl(read_status(), ST_IDLE, "after reset");
      check_byte(out_data, 8'h00, $sformatf("reset row byte %0d", i));
    end
  endtask

  task automatic run_pattern(input int t);
    int gap;
    int hold;
    int edges;
    int ready_pulses;
    int glitch_edge;
    gap         = 1 + int'($urandom % MAX_IDLE_GAP);
    hold        = `CONV_OUTS + int'($urandom % MAX_HOLD_EXTRA);
    glitch_edge = 8 + int'($urandom % 20);  // lands in a load or compute phase.
    repeat (gap) begin
      @(posedge clk);
      seed <= seeds[t];
      @(negedge clk);
      check_ctrl(read_status(), ST_IDLE, "idle gap");
    end
    @(posedge clk);
    ap_start <= 1'b1;
    @(posedge clk);
    ap_start <= 1'b0;                          // this edge is the start edge.
    seed     <= conv_pkg::seed_t'($urandom);   // only the start edge may take the seed.
    edges        = 1;
    ready_pulses = 0;
    @(negedge clk);
    check_ctrl(read_status(), ST_BUSY, "busy after start");
    while (!ap_done) begin
      if (ap_ready) ready_pulses++;
      @(posedge clk);
      edges++;
      ap_start <= (edges == glitch_edge);      // a start while busy must be ignored.
      @(negedge clk);
    end
    check_count(edges, DONE_EDGES, $sformatf("pattern %0d edges from start to done", t));
    check_count(ready_pulses, 1, $sformatf("pattern %0d ap_ready pulses", t));
    for (int c = 0; c < hold; c++) begin
      @(posedge clk);
      out_sel <= conv_pkg::out_idx_t'(c % `CONV_OUTS);
      @(negedge clk);
      check_ctrl(read_status(), ST_DONE, "waiting for ap_continue");
      check_byte(out_data, exp_rows[t][c % `CONV_OUTS],
                 $sformatf("pattern %0d row byte %0d", t, c % `CONV_OUTS));
    end
    @(posedge clk);
    ap_continue <= 1'b1;
    @(posedge clk);
    ap_continue <= 1'b0;
    @(negedge clk);
    check_ctrl(read_status(), ST_IDLE, "after ap_continue");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // main sequence and watchdog
  // ~~~~~~~~~~~~~~~~~~~~
  initial begin
    arst_n      = 1'b0;
    ap_start    = 1'b0;
    ap_continue = 1'b0;
    seed        = '0;
    out_sel     = '0;
    void'($urandom(32'h66e6));
    load_patterns();
    if (n_patterns == 0) begin
      $display("ERROR: the pattern file holds no usable pattern lines");
      stop_with_failure();
    end else begin
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
      check_reset_state();
      for (int t = 0; t < n_patterns; t++) begin
        run_pattern(t);
      end
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  initial begin
    int limit;
    wait (n_patterns > 0);
    limit = RESET_CYCLES + 2 * `CONV_OUTS + n_patterns *
            (DONE_EDGES + MAX_IDLE_GAP + `CONV_OUTS + MAX_HOLD_EXTRA + 10);
    repeat (limit) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, the DUT stopped responding", limit);
    stop_with_failure();
  end

endmodule

// File: sim/conv_patterns.txt
# seed  out0 out1 out2 out3 out4 out5 out6 out7   (hex)
# each out byte is the 3-tap convolution of LFSR bytes, wrapped to 8 bits
ace1  3c b4 b8 88 0c 38 80 88
0000  00 00 00 00 00 00 00 00
1234  1b 3a 10 88 21 ca 58 09
ffff  a3 d3 eb 77 bd e0 f1 f9
ace1  3c b4 b8 88 0c 38 80 88

// File: all.f
+incdir+hdl
hdl/conv_pkg.sv
hdl/conv_ctl_if.sv
hdl/conv_ctrl_fsm.sv
hdl/conv_loop_counter.sv
hdl/lfsr_source.sv
hdl/conv_datapath.sv
hdl/conv_layer_random.sv
sim/conv_layer_random_assert.sv
sim/tb_conv_layer_random.sv

// File: run.sh
#!/bin/sh
verilator --binary --assert -Wno-fatal -f all.f --top-module tb_conv_layer_random \
  && ./obj_dir/Vtb_conv_layer_random || exit 1
